/* src/tlb_defs.svh */
`ifndef TLB_DEFS_SVH
`define TLB_DEFS_SVH

// geometry
`define TLB_NUM 64
`define TLB_IDX_W 6

// field widths of one entry
`define TLB_VPPN_W 19
`define TLB_ASID_W 10
`define TLB_PPN_W 20
`define TLB_PS_W 6

// page sizes as log2 of the page in bytes
`define TLB_PS_4K 6'd12
`define TLB_PS_HUGE 6'd21

// invtlb op field
`define TLB_INV_OP_W 5

`endif

/* src/tlbPkg.sv */
`include "tlb_defs.svh"

package tlbPkg;

    // huge view of a vppn, low part falls inside the page
    typedef struct packed {
        logic [9:0] tag;
        logic       oddSel;
        logic [7:0] low;
    } tlbVppnHuge_t;

    typedef union packed {
        logic [`TLB_VPPN_W-1:0] full;
        tlbVppnHuge_t           huge;
    } tlbVppn_u;

    typedef struct packed {
        logic [`TLB_PPN_W-1:0] ppn;
        logic [1:0]            plv;
        logic [1:0]            mat;
        logic                  d;
        logic                  v;
    } tlbPageHalf_t;

    typedef struct packed {
        tlbVppn_u               vppn;
        logic [`TLB_ASID_W-1:0] asid;
        logic                   g;
        logic [`TLB_PS_W-1:0]   ps;
        logic                   e;
        tlbPageHalf_t           half0;
        tlbPageHalf_t           half1;
    } tlbEntry_t;

    typedef struct packed {
        logic                   valid;
        tlbVppn_u               vppn;
        logic                   oddPage;
        logic [`TLB_ASID_W-1:0] asid;
    } tlbSearchReq_t;

    typedef struct packed {
        logic                  valid;
        logic                  found;
        logic [`TLB_IDX_W-1:0] index;
        logic [`TLB_PS_W-1:0]  ps;
        tlbPageHalf_t          half;
    } tlbSearchRsp_t;

    typedef struct packed {
        logic                  valid;
        logic [`TLB_IDX_W-1:0] index;
        tlbEntry_t             entry;
    } tlbWriteReq_t;

    typedef struct packed {
        logic                  valid;
        logic [`TLB_IDX_W-1:0] index;
    } tlbReadReq_t;

    typedef struct packed {
        logic      valid;
        tlbEntry_t entry;
    } tlbReadRsp_t;

    typedef struct packed {
        logic                     valid;
        logic [`TLB_INV_OP_W-1:0] op;
        logic [`TLB_ASID_W-1:0]   asid;
        tlbVppn_u                 vppn;
    } tlbInvReq_t;

    // vppn compare, width depends on the entry's page size
    function automatic logic vppnMatch(tlbEntry_t ent, tlbVppn_u key);
        if (ent.ps == `TLB_PS_4K) begin
            return ent.vppn.full == key.full;
        end
        return ent.vppn.huge.tag == key.huge.tag;
    endfunction

endpackage

/* src/tlbEntryStore.sv */
`timescale 1ns/1ns
`include "tlb_defs.svh"

module tlbEntryStore (
    input  logic                                Clk,
    input  logic                                rstN,
    input  tlbPkg::tlbWriteReq_t                wrReq,
    input  tlbPkg::tlbInvReq_t                  invReq,
    input  logic [`TLB_NUM-1:0]                 invClear,
    input  tlbPkg::tlbReadReq_t                 rdReq,
    output tlbPkg::tlbReadRsp_t                 rdRsp,
    output tlbPkg::tlbEntry_t [`TLB_NUM-1:0]    entries
);

    logic              rdValidQ;
    tlbPkg::tlbEntry_t rdEntryQ;

    // write wins over invalidate in the same cycle
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            entries <= '0;
        end else if (wrReq.valid) begin
            entries[wrReq.index] <= wrReq.entry;
        end else if (invReq.valid) begin
            for (int i = 0; i < `TLB_NUM; i++) begin
                if (invClear[i]) begin
                    entries[i].e <= 1'b0;
                end
            end
        end
    end

    // read port, one cycle latency
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            rdValidQ <= 1'b0;
        end else begin
            rdValidQ <= rdReq.valid;
        end
    end

    // sees the array before a write at the same edge
    always_ff @(posedge Clk) begin
        if (rdReq.valid) begin
            rdEntryQ <= entries[rdReq.index];
        end
    end

    assign rdRsp.valid = rdValidQ;
    assign rdRsp.entry = rdEntryQ;

endmodule

/* src/tlbInvSelect.sv */
`timescale 1ns/1ns
`include "tlb_defs.svh"

module tlbInvSelect (
    input  tlbPkg::tlbInvReq_t                  invReq,
    input  tlbPkg::tlbEntry_t [`TLB_NUM-1:0]    entries,
    output logic [`TLB_NUM-1:0]                 invClear
);

    for (genvar i = 0; i < `TLB_NUM; i++) begin : gEntry
        logic asidHit;
        logic vppnHit;
        logic clear;

        assign asidHit = (entries[i].asid == invReq.asid);
        assign vppnHit = tlbPkg::vppnMatch(entries[i], invReq.vppn);

        // invtlb op decode
        always_comb begin
            case (invReq.op)
                5'd0, 5'd1: clear = 1'b1;
                5'd2:       clear = entries[i].g;
                5'd3:       clear = !entries[i].g;
                5'd4:       clear = !entries[i].g && asidHit;
                5'd5:       clear = !entries[i].g && asidHit && vppnHit;
                // same as a search hit, E ignored
                5'd6:       clear = (entries[i].g || asidHit) && vppnHit;
                default:    clear = 1'b0;
            endcase
        end

        assign invClear[i] = clear;
    end

endmodule

/* src/tlbLookup.sv */
`timescale 1ns/1ns
`include "tlb_defs.svh"

module tlbLookup (
    input  logic                                Clk,
    input  logic                                rstN,
    input  tlbPkg::tlbSearchReq_t               searchReq,
    input  tlbPkg::tlbEntry_t [`TLB_NUM-1:0]    entries,
    output tlbPkg::tlbSearchRsp_t               searchRsp
);

    logic [`TLB_NUM-1:0]   hitVec;
    logic [`TLB_IDX_W-1:0] hitIdx;
    logic                  found;
    tlbPkg::tlbEntry_t     hitEntry;
    logic                  parity;
    tlbPkg::tlbPageHalf_t  hitHalf;

    logic                  rspValid;
    logic                  rspFound;
    logic [`TLB_IDX_W-1:0] rspIdx;
    logic [`TLB_PS_W-1:0]  rspPs;
    tlbPkg::tlbPageHalf_t  rspHalf;

    // per-entry match, E and asid-or-global for every page size
    for (genvar i = 0; i < `TLB_NUM; i++) begin : gHit
        assign hitVec[i] = entries[i].e
                        && (entries[i].g || (entries[i].asid == searchReq.asid))
                        && tlbPkg::vppnMatch(entries[i], searchReq.vppn);
    end

    // lowest index wins
    always_comb begin
        hitIdx = '0;
        for (int i = `TLB_NUM - 1; i >= 0; i--) begin
            if (hitVec[i]) begin
                hitIdx = i[`TLB_IDX_W-1:0];
            end
        end
    end

    assign found    = |hitVec;
    assign hitEntry = entries[hitIdx];

    // even/odd half: oddPage for 4K, first bit above the page offset otherwise
    assign parity  = (hitEntry.ps == `TLB_PS_4K) ? searchReq.oddPage
                                                 : searchReq.vppn.huge.oddSel;
    assign hitHalf = parity ? hitEntry.half1 : hitEntry.half0;

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            rspValid <= 1'b0;
        end else begin
            rspValid <= searchReq.valid;
        end
    end

    // result fields hold between requests
    always_ff @(posedge Clk) begin
        if (searchReq.valid) begin
            rspFound <= found;
            rspIdx   <= hitIdx;
            rspPs    <= found ? hitEntry.ps : '0;
            rspHalf  <= found ? hitHalf : '0;
        end
    end

    assign searchRsp.valid = rspValid;
    assign searchRsp.found = rspFound;
    assign searchRsp.index = rspIdx;
    assign searchRsp.ps    = rspPs;
    assign searchRsp.half  = rspHalf;

endmodule

/* src/tlbTop.sv */
`timescale 1ns/1ns
`include "tlb_defs.svh"

module tlbTop (
    input  logic                    Clk,
    input  logic                    rstN,
    input  tlbPkg::tlbSearchReq_t   fetchReq,
    output tlbPkg::tlbSearchRsp_t   fetchRsp,
    input  tlbPkg::tlbSearchReq_t   dataReq,
    output tlbPkg::tlbSearchRsp_t   dataRsp,
    input  tlbPkg::tlbWriteReq_t    wrReq,
    input  tlbPkg::tlbReadReq_t     rdReq,
    output tlbPkg::tlbReadRsp_t     rdRsp,
    input  tlbPkg::tlbInvReq_t      invReq
);

    // shared entry array, read by all three consumers
    tlbPkg::tlbEntry_t [`TLB_NUM-1:0] entries;
    logic [`TLB_NUM-1:0]              invClear;

    tlbEntryStore u_store (
        .Clk      (Clk),
        .rstN     (rstN),
        .wrReq    (wrReq),
        .invReq   (invReq),
        .invClear (invClear),
        .rdReq    (rdReq),
        .rdRsp    (rdRsp),
        .entries  (entries)
    );

    tlbInvSelect u_invSel (
        .invReq   (invReq),
        .entries  (entries),
        .invClear (invClear)
    );

    // instruction side
    tlbLookup u_fetchLookup (
        .Clk       (Clk),
        .rstN      (rstN),
        .searchReq (fetchReq),
        .entries   (entries),
        .searchRsp (fetchRsp)
    );

    // load/store side
    tlbLookup u_dataLookup (
        .Clk       (Clk),
        .rstN      (rstN),
        .searchReq (dataReq),
        .entries   (entries),
        .searchRsp (dataRsp)
    );

endmodule

/* sim/tlbTb.sv */
`timescale 1ns/1ns
`include "tlb_defs.svh"

module tlbTb;

    // one table row where zero fields leave a port idle
    typedef struct packed {
        tlbPkg::tlbWriteReq_t  wr;
        tlbPkg::tlbSearchReq_t fetch;
        tlbPkg::tlbSearchRsp_t fetchWant;
        tlbPkg::tlbSearchReq_t data;
        tlbPkg::tlbSearchRsp_t dataWant;
        tlbPkg::tlbReadReq_t   rd;
        tlbPkg::tlbEntry_t     rdWant;
        tlbPkg::tlbInvReq_t    inv;
    } stimRow_t;

    logic                  Clk;
    logic                  rstN;
    tlbPkg::tlbSearchReq_t fetchReq;
    tlbPkg::tlbSearchRsp_t fetchRsp;
    tlbPkg::tlbSearchReq_t dataReq;
    tlbPkg::tlbSearchRsp_t dataRsp;
    tlbPkg::tlbWriteReq_t  wrReq;
    tlbPkg::tlbReadReq_t   rdReq;
    tlbPkg::tlbReadRsp_t   rdRsp;
    tlbPkg::tlbInvReq_t    invReq;

    stimRow_t          rows[$];
    logic              tableReady = 1'b0;
    tlbPkg::tlbEntry_t eLocal4k;
    tlbPkg::tlbEntry_t eGlobal4k;
    tlbPkg::tlbEntry_t eLocalHuge;
    tlbPkg::tlbEntry_t eGlobalHuge;
    tlbPkg::tlbEntry_t eAlias4k;

    tlbTop u_tlbTop (
        .Clk      (Clk),
        .rstN     (rstN),
        .fetchReq (fetchReq),
        .fetchRsp (fetchRsp),
        .dataReq  (dataReq),
        .dataRsp  (dataRsp),
        .wrReq    (wrReq),
        .rdReq    (rdReq),
        .rdRsp    (rdRsp),
        .invReq   (invReq)
    );

    always #4 Clk = ~Clk;

    function automatic tlbPkg::tlbEntry_t makeEntry(input logic [`TLB_VPPN_W-1:0] vppn,
                                                    input logic [`TLB_ASID_W-1:0] asid,
                                                    input logic g,
                                                    input logic [`TLB_PS_W-1:0] ps);
        tlbPkg::tlbEntry_t ent;
        logic [31:0]       rnd;
        ent = '0;
        ent.vppn.full = vppn;
        ent.asid = asid;
        ent.g = g;
        ent.ps = ps;
        ent.e = 1'b1;
        rnd = $urandom();
        ent.half0 = {rnd[`TLB_PPN_W-1:0], 2'd0, 2'd1, 1'b0, 1'b1};
        rnd = $urandom();
        ent.half1 = {rnd[`TLB_PPN_W-1:0], 2'd3, 2'd1, 1'b1, 1'b1};
        return ent;
    endfunction

    function automatic tlbPkg::tlbSearchReq_t searchKey(input logic [`TLB_VPPN_W-1:0] vppn,
                                                        input logic odd,
                                                        input logic [`TLB_ASID_W-1:0] asid);
        tlbPkg::tlbSearchReq_t req;
        req.valid = 1'b1;
        req.vppn.full = vppn;
        req.oddPage = odd;
        req.asid = asid;
        return req;
    endfunction

    function automatic tlbPkg::tlbSearchRsp_t hitRsp(input logic [`TLB_IDX_W-1:0] idx,
                                                     input tlbPkg::tlbEntry_t ent,
                                                     input logic useHalf1);
        tlbPkg::tlbSearchRsp_t rsp;
        rsp.valid = 1'b1;
        rsp.found = 1'b1;
        rsp.index = idx;
        rsp.ps = ent.ps;
        rsp.half = useHalf1 ? ent.half1 : ent.half0;
        return rsp;
    endfunction

    function automatic tlbPkg::tlbSearchRsp_t missRsp();
        tlbPkg::tlbSearchRsp_t rsp;
        rsp = '0;
        rsp.valid = 1'b1;
        return rsp;
    endfunction

    task automatic pushWrite(input logic [`TLB_IDX_W-1:0] idx, input tlbPkg::tlbEntry_t ent);
        stimRow_t r;
        r = '0;
        r.wr = {1'b1, idx, ent};
        rows.push_back(r);
    endtask

    task automatic pushRead(input logic [`TLB_IDX_W-1:0] idx, input tlbPkg::tlbEntry_t want);
        stimRow_t r;
        r = '0;
        r.rd = {1'b1, idx};
        r.rdWant = want;
        rows.push_back(r);
    endtask

    task automatic pushSearch(input tlbPkg::tlbSearchReq_t fKey,
                              input tlbPkg::tlbSearchRsp_t fWant,
                              input tlbPkg::tlbSearchReq_t dKey,
                              input tlbPkg::tlbSearchRsp_t dWant);
        stimRow_t r;
        r = '0;
        r.fetch = fKey;
        r.fetchWant = fWant;
        r.data = dKey;
        r.dataWant = dWant;
        rows.push_back(r);
    endtask

    task automatic pushInv(input logic [`TLB_INV_OP_W-1:0] op,
                           input logic [`TLB_ASID_W-1:0] asid,
                           input logic [`TLB_VPPN_W-1:0] vppn);
        stimRow_t r;
        r = '0;
        r.inv = {1'b1, op, asid, vppn};
        rows.push_back(r);
    endtask

    task automatic buildTable();
        stimRow_t r;
        eLocal4k    = makeEntry(19'h12345, 10'h011, 1'b0, `TLB_PS_4K);
        eGlobal4k   = makeEntry(19'h00abc, 10'h022, 1'b1, `TLB_PS_4K);
        eLocalHuge  = makeEntry(19'h2aa00, 10'h011, 1'b0, `TLB_PS_HUGE);
        eGlobalHuge = makeEntry(19'h2ab45, 10'h011, 1'b1, `TLB_PS_HUGE);
        eAlias4k    = makeEntry(19'h12345, 10'h044, 1'b0, `TLB_PS_4K);

        // empty after reset
        r = '0;
        r.fetch = searchKey(19'h12345, 1'b0, 10'h011);
        r.fetchWant = missRsp();
        r.data = searchKey(19'h2ab7f, 1'b1, 10'h000);
        r.dataWant = missRsp();
        r.rd = {1'b1, 6'd3};
        rows.push_back(r);
        pushRead(6'd63, '0);

        // read in the write cycle sees the old entry
        r = '0;
        r.wr = {1'b1, 6'd3, eLocal4k};
        r.rd = {1'b1, 6'd3};
        rows.push_back(r);
        pushWrite(6'd5, eGlobal4k);
        pushWrite(6'd9, eLocalHuge);
        pushWrite(6'd12, eGlobalHuge);
        pushWrite(6'd20, eAlias4k);
        pushRead(6'd3, eLocal4k);
        pushRead(6'd9, eLocalHuge);
        pushRead(6'd20, eAlias4k);

        // 4K pages
        pushSearch(searchKey(19'h12345, 1'b0, 10'h011), hitRsp(6'd3, eLocal4k, 1'b0),
                   searchKey(19'h12345, 1'b1, 10'h011), hitRsp(6'd3, eLocal4k, 1'b1));
        pushSearch(searchKey(19'h12345, 1'b1, 10'h044), hitRsp(6'd20, eAlias4k, 1'b1),
                   searchKey(19'h00abc, 1'b0, 10'h3ff), hitRsp(6'd5, eGlobal4k, 1'b0));
        pushSearch(searchKey(19'h12345, 1'b0, 10'h055), missRsp(),
                   searchKey(19'h00abd, 1'b0, 10'h022), missRsp());

        // huge pages where 9 and 12 overlap
        pushSearch(searchKey(19'h2ab7f, 1'b0, 10'h011), hitRsp(6'd9, eLocalHuge, 1'b1),
                   searchKey(19'h2aa3c, 1'b1, 10'h011), hitRsp(6'd9, eLocalHuge, 1'b0));
        pushSearch(searchKey(19'h2aaff, 1'b0, 10'h033), hitRsp(6'd12, eGlobalHuge, 1'b0),
                   searchKey(19'h2ca00, 1'b0, 10'h011), missRsp());

        // op 7 is not an invalidate
        pushInv(5'd7, 10'h000, 19'h00000);
        pushSearch(searchKey(19'h12345, 1'b0, 10'h011), hitRsp(6'd3, eLocal4k, 1'b0),
                   searchKey(19'h2aaff, 1'b1, 10'h033), hitRsp(6'd12, eGlobalHuge, 1'b0));
        pushSearch(searchKey(19'h00abc, 1'b1, 10'h000), hitRsp(6'd5, eGlobal4k, 1'b1),
                   searchKey(19'h12345, 1'b0, 10'h044), hitRsp(6'd20, eAlias4k, 1'b0));

        pushInv(5'd5, 10'h011, 19'h12345);
        pushSearch(searchKey(19'h12345, 1'b0, 10'h011), missRsp(),
                   searchKey(19'h12345, 1'b0, 10'h044), hitRsp(6'd20, eAlias4k, 1'b0));
        pushInv(5'd6, 10'h033, 19'h2aa00);
        pushSearch(searchKey(19'h2aa00, 1'b0, 10'h033), missRsp(),
                   searchKey(19'h2aa00, 1'b0, 10'h011), hitRsp(6'd9, eLocalHuge, 1'b0));
        pushInv(5'd4, 10'h044, 19'h00000);
        pushSearch(searchKey(19'h12345, 1'b1, 10'h044), missRsp(),
                   searchKey(19'h00abc, 1'b0, 10'h000), hitRsp(6'd5, eGlobal4k, 1'b0));
        pushInv(5'd2, 10'h000, 19'h00000);
        pushSearch(searchKey(19'h00abc, 1'b0, 10'h000), missRsp(),
                   searchKey(19'h2ab00, 1'b0, 10'h011), hitRsp(6'd9, eLocalHuge, 1'b1));
        pushWrite(6'd5, eGlobal4k);
        pushInv(5'd3, 10'h000, 19'h00000);
        pushSearch(searchKey(19'h2ab00, 1'b0, 10'h011), missRsp(),
                   searchKey(19'h00abc, 1'b0, 10'h000), hitRsp(6'd5, eGlobal4k, 1'b0));

        pushWrite(6'd3, eLocal4k);
        pushWrite(6'd5, eGlobal4k);
        pushInv(5'd1, 10'h000, 19'h00000);
        pushSearch(searchKey(19'h12345, 1'b0, 10'h011), missRsp(),
                   searchKey(19'h00abc, 1'b0, 10'h000), missRsp());

        // write and invalidate together where the write wins
        pushWrite(6'd3, eLocal4k);
        pushWrite(6'd5, eGlobal4k);
        pushWrite(6'd12, eGlobalHuge);
        r = '0;
        r.wr = {1'b1, 6'd20, eAlias4k};
        r.inv = {1'b1, 5'd0, 10'h000, 19'h00000};
        rows.push_back(r);
        pushSearch(searchKey(19'h12345, 1'b0, 10'h011), hitRsp(6'd3, eLocal4k, 1'b0),
                   searchKey(19'h12345, 1'b1, 10'h044), hitRsp(6'd20, eAlias4k, 1'b1));
        pushSearch(searchKey(19'h00abc, 1'b1, 10'h3ff), hitRsp(6'd5, eGlobal4k, 1'b1),
                   searchKey(19'h2ab80, 1'b0, 10'h033), hitRsp(6'd12, eGlobalHuge, 1'b1));
        pushInv(5'd0, 10'h000, 19'h00000);
        pushSearch(searchKey(19'h00abc, 1'b0, 10'h000), missRsp(),
                   searchKey(19'h2ab80, 1'b0, 10'h033), missRsp());
    endtask

    task automatic driveRow(input stimRow_t r);
        wrReq = r.wr;
        fetchReq = r.fetch;
        dataReq = r.data;
        rdReq = r.rd;
        invReq = r.inv;
    endtask

    task automatic checkValue(input string name, input logic [127:0] got,
                              input logic [127:0] want);
        assert (got === want) else begin
            $display("mismatch %s expected %h actual %h", name, want, got);
            $display("TEST FAILED");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic checkSearch(input string port, input int k,
                               input tlbPkg::tlbSearchReq_t req,
                               input tlbPkg::tlbSearchRsp_t want,
                               input tlbPkg::tlbSearchRsp_t got);
        checkValue($sformatf("row %0d %s.valid", k, port), 128'(got.valid), 128'(req.valid));
        if (req.valid) begin
            checkValue($sformatf("row %0d %s.found", k, port), 128'(got.found), 128'(want.found));
            checkValue($sformatf("row %0d %s.index", k, port), 128'(got.index), 128'(want.index));
            checkValue($sformatf("row %0d %s.ps", k, port), 128'(got.ps), 128'(want.ps));
            checkValue($sformatf("row %0d %s.half", k, port), 128'(got.half), 128'(want.half));
        end
    endtask

    task automatic checkRow(input int k);
        stimRow_t r;
        r = rows[k];
        checkSearch("fetchRsp", k, r.fetch, r.fetchWant, fetchRsp);
        checkSearch("dataRsp", k, r.data, r.dataWant, dataRsp);
        checkValue($sformatf("row %0d rdRsp.valid", k), 128'(rdRsp.valid), 128'(r.rd.valid));
        if (r.rd.valid) begin
            checkValue($sformatf("row %0d rdRsp.entry", k), 128'(rdRsp.entry), 128'(r.rdWant));
        end
    endtask

    initial begin
        int unsigned seedDummy;
        Clk = 1'b0;
        rstN = 1'b0;
        driveRow('0);
        seedDummy = $urandom(62);
        buildTable();
        tableReady = 1'b1;
        repeat (10) @(posedge Clk);
        #1 rstN = 1'b1;
        // response of row k is checked while row k+1 is driven
        for (int k = 0; k < rows.size(); k++) begin
            @(posedge Clk);
            #1;
            if (k > 0) begin
                checkRow(k - 1);
            end
            driveRow(rows[k]);
        end
        @(posedge Clk);
        #1;
        checkRow(rows.size() - 1);
        driveRow('0);
        $display("TEST OK");
        $finish;
    end

    initial begin
        wait (tableReady);
        #((rows.size() + 20) * 8 * 4);
        $display("timeout, the run did not reach its end in time");
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

/* build.f */
+incdir+src
src/tlbPkg.sv
src/tlbEntryStore.sv
src/tlbInvSelect.sv
src/tlbLookup.sv
src/tlbTop.sv
sim/tlbTb.sv

/* Makefile */
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ns \
		--top-module tlbTb -f build.f -o simv
	./obj_dir/simv 2>&1 | tee $(LOG)
	@if grep -q "TEST OK" $(LOG); then \
		echo "result: pass"; \
	else \
		echo "result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
